// File: filelist.f
hs_pkg.sv
hs_ram.sv
hs_arbiter.sv
host_xfer.sv
cpu_port.sv
hs_top.sv
hs_arbiter_assert.sv
tb_hs_top.sv

// File: tb_hs_top.sv
// Testbench for the high-score store
// Drives the host loader and the CPU port, keeps an array model of the
// table and compares every read against it
module tb_hs_top;

	localparam int ADDR_W     = hs_pkg::HS_ADDR_W_DEF;
	localparam int DATA_W     = hs_pkg::HS_DATA_W_DEF;
	localparam int DEPTH      = 1 << ADDR_W;
	localparam int STREAM_LEN = 64;
	localparam int WAIT_LIMIT = 200;

	logic              clk_12;
	logic              reset_i;
	logic              ioctl_wr_i;
	logic              ioctl_upload_i;
	logic [ADDR_W-1:0] ioctl_addr_i;
	logic [DATA_W-1:0] ioctl_dout_i;
	logic [DATA_W-1:0] ioctl_din_o;
	logic              host_busy_o;
	logic              cpu_cs_i;
	logic              cpu_we_i;
	logic [ADDR_W-1:0] cpu_addr_i;
	logic [DATA_W-1:0] cpu_wdata_i;
	logic [DATA_W-1:0] cpu_rdata_o;
	logic              cpu_ready_o;

	logic [DATA_W-1:0] model [0:DEPTH-1];
	logic [ADDR_W-1:0] stream_addr [0:1][0:STREAM_LEN-1];
	logic [DATA_W-1:0] stream_data [0:1][0:STREAM_LEN-1];
	logic [31:0]       lcg_state;
	logic [31:0]       rnd;
	int                err_count;
	int                failed_tests;
	int                test_start;
	bit                stuck;

	hs_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dut_i (.*);

	initial begin
		clk_12 = 1'b0;
		forever #20 clk_12 = ~clk_12;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int total_errors();
		return err_count + dut_i.u_arb.u_assert.fail_count;
	endfunction

	task automatic check_value(input string name, input int addr,
		input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL t=%0t %s addr %0d expected %h got %h",
				$time, name, addr, expected, actual);
			err_count++;
		end
	endtask

	task automatic give_up(input string what);
		$display("ERROR t=%0t %s did not finish before the timeout", $time, what);
		err_count++;
		stuck = 1'b1;
	endtask

	// Called on a falling edge, returns on the falling edge where busy is low again
	task automatic host_strobe(input logic upload, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		int cnt;
		if (!stuck) begin
			ioctl_wr_i     = 1'b1;
			ioctl_upload_i = upload;
			ioctl_addr_i   = addr;
			ioctl_dout_i   = data;
			@(negedge clk_12);
			ioctl_wr_i = 1'b0;
			if (!host_busy_o) begin
				$display("ERROR t=%0t host strobe was not accepted", $time);
				err_count++;
			end
			cnt = 0;
			while (host_busy_o && cnt < WAIT_LIMIT) begin
				@(negedge clk_12);
				cnt++;
			end
			if (host_busy_o) begin
				give_up("host transfer");
			end
		end
	endtask

	// With hold_cs the task returns on the ready edge and leaves cs high,
	// so the next call lines up back to back with RELEASE
	task automatic cpu_cycle(input logic we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input logic hold_cs);
		int cnt;
		if (!stuck) begin
			cpu_cs_i    = 1'b1;
			cpu_we_i    = we;
			cpu_addr_i  = addr;
			cpu_wdata_i = data;
			cnt = 0;
			do begin
				@(negedge clk_12);
				cnt++;
			end while (!cpu_ready_o && cnt < WAIT_LIMIT);
			if (!cpu_ready_o) begin
				give_up("CPU cycle");
			end else if (!hold_cs) begin
				cpu_cs_i = 1'b0;
				@(negedge clk_12);
			end
		end
	endtask

	task automatic end_test(input string name);
		if (total_errors() == test_start) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, total_errors() - test_start);
			failed_tests++;
		end
		test_start = total_errors();
	endtask

	initial begin
		reset_i        = 1'b1;
		ioctl_wr_i     = 1'b0;
		ioctl_upload_i = 1'b0;
		ioctl_addr_i   = '0;
		ioctl_dout_i   = '0;
		cpu_cs_i       = 1'b0;
		cpu_we_i       = 1'b0;
		cpu_addr_i     = '0;
		cpu_wdata_i    = '0;
		lcg_state      = 32'd43462;
		err_count      = 0;
		failed_tests   = 0;
		test_start     = 0;
		stuck          = 1'b0;
		// Both streams are drawn up front so forked threads never share the LCG
		for (int i = 0; i < STREAM_LEN; i++) begin
			for (int p = 0; p < 2; p++) begin
				rnd = lcg_next();
				stream_addr[p][i] = rnd[16 +: ADDR_W];
				stream_data[p][i] = rnd[8 +: DATA_W];
			end
		end
		repeat (8) @(negedge clk_12);
		reset_i = 1'b0;

		repeat (20) begin
			@(negedge clk_12);
			if (host_busy_o !== 1'b0 || cpu_ready_o !== 1'b0) begin
				$display("FAIL t=%0t host_busy_o/cpu_ready_o expected 0/0 got %b/%b",
					$time, host_busy_o, cpu_ready_o);
				err_count++;
			end
		end
		end_test("idle after reset");

		for (int a = 0; a < DEPTH; a++) begin
			host_strobe(1'b0, ADDR_W'(a), stream_data[0][a]);
			model[a] = stream_data[0][a];
		end
		for (int a = 0; a < DEPTH; a++) begin
			cpu_cycle(1'b0, ADDR_W'(a), '0, 1'b0);
			check_value("cpu_rdata_o", a, model[a], cpu_rdata_o);
		end
		end_test("host download, cpu read");

		for (int i = 0; i < DEPTH / 2; i++) begin
			cpu_cycle(1'b1, stream_addr[1][i], stream_data[1][i], 1'b0);
			model[stream_addr[1][i]] = stream_data[1][i];
		end
		for (int a = 0; a < DEPTH; a++) begin
			host_strobe(1'b1, ADDR_W'(a), '0);
			check_value("ioctl_din_o", a, model[a], ioctl_din_o);
		end
		end_test("cpu write, host upload");

		// Both peers hammer the same eight entries, model follows completion order
		fork
			begin
				logic [ADDR_W-1:0] a;
				for (int i = 0; i < STREAM_LEN; i++) begin
					a = stream_addr[0][i] & ADDR_W'(7);
					host_strobe(1'b0, a, stream_data[0][i]);
					model[a] = stream_data[0][i];
				end
			end
			begin
				logic [ADDR_W-1:0] a;
				for (int i = 0; i < STREAM_LEN; i++) begin
					a = stream_addr[1][i] & ADDR_W'(7);
					cpu_cycle(1'b1, a, stream_data[1][i], 1'b0);
					model[a] = stream_data[1][i];
				end
			end
		join
		for (int a = 0; a < DEPTH; a++) begin
			cpu_cycle(1'b0, ADDR_W'(a), '0, 1'b0);
			check_value("cpu_rdata_o", a, model[a], cpu_rdata_o);
		end
		end_test("contention");

		// CPU stays in the lower half, host reads the upper half
		fork
			begin
				logic [ADDR_W-1:0] a;
				for (int i = 0; i < DEPTH / 4; i++) begin
					a = stream_addr[0][i] & ADDR_W'(31);
					cpu_cycle(1'b1, a, stream_data[1][i], 1'b1);
					model[a] = stream_data[1][i];
					cpu_cycle(1'b0, a, '0, 1'b1);
					check_value("cpu_rdata_o", int'(a), model[a], cpu_rdata_o);
				end
				cpu_cs_i = 1'b0;
			end
			begin
				for (int a = DEPTH / 2; a < DEPTH; a++) begin
					host_strobe(1'b1, ADDR_W'(a), '0);
					check_value("ioctl_din_o", a, model[a], ioctl_din_o);
				end
			end
		join
		repeat (4) @(negedge clk_12);
		end_test("back to back handshakes");

		$display("summary: 5 tests, %0d failed, %0d errors", failed_tests, total_errors());
		if (total_errors() == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: hs_arbiter_assert.sv
// Handshake and RAM strobe checks on the table arbiter
// Bound into every hs_arbiter instance
module hs_arbiter_assert (
	input logic clk_12,
	input logic reset_i,
	input logic host_req_i,
	input logic host_ack_i,
	input logic cpu_req_i,
	input logic cpu_ack_i,
	input logic ram_en_i
);

	int fail_count = 0;

	// ========================================
	// Ack side of the four-phase channels
	// ========================================

	// An ack may only come up against a raised request
	host_ack_rise: assert property (@(posedge clk_12) disable iff (reset_i)
		$rose(host_ack_i) |-> host_req_i)
		else begin
			$error("host ack rose with no request");
			fail_count++;
		end

	cpu_ack_rise: assert property (@(posedge clk_12) disable iff (reset_i)
		$rose(cpu_ack_i) |-> cpu_req_i)
		else begin
			$error("cpu ack rose with no request");
			fail_count++;
		end

	// Once up, ack stays until the peer lets go of req
	host_ack_hold: assert property (@(posedge clk_12) disable iff (reset_i)
		host_ack_i && host_req_i |=> host_ack_i)
		else begin
			$error("host ack fell while the request was still high");
			fail_count++;
		end

	cpu_ack_hold: assert property (@(posedge clk_12) disable iff (reset_i)
		cpu_ack_i && cpu_req_i |=> cpu_ack_i)
		else begin
			$error("cpu ack fell while the request was still high");
			fail_count++;
		end

	// ========================================
	// Single owner
	// ========================================

	ack_onehot: assert property (@(posedge clk_12) disable iff (reset_i)
		!(host_ack_i && cpu_ack_i))
		else begin
			$error("host and cpu acks high together");
			fail_count++;
		end

	// One RAM access per grant
	ram_en_single: assert property (@(posedge clk_12) disable iff (reset_i)
		ram_en_i |=> !ram_en_i)
		else begin
			$error("ram_en high for two cycles in a row");
			fail_count++;
		end

endmodule

bind hs_arbiter hs_arbiter_assert u_assert (
	.clk_12     (clk_12),
	.reset_i    (reset_i),
	.host_req_i (host_req_i),
	.host_ack_i (host_ack_o),
	.cpu_req_i  (cpu_req_i),
	.cpu_ack_i  (cpu_ack_o),
	.ram_en_i   (ram_en_o)
);

// File: hs_top.sv
// High-score store top level
// Host loader and CPU port share one table RAM through the arbiter
module hs_top #(
	parameter int ADDR_W = hs_pkg::HS_ADDR_W_DEF,
	parameter int DATA_W = hs_pkg::HS_DATA_W_DEF
) (
	input  logic              clk_12,
	input  logic              reset_i,
	// Host loader
	input  logic              ioctl_wr_i,
	input  logic              ioctl_upload_i,
	input  logic [ADDR_W-1:0] ioctl_addr_i,
	input  logic [DATA_W-1:0] ioctl_dout_i,
	output logic [DATA_W-1:0] ioctl_din_o,
	output logic              host_busy_o,
	// Game CPU
	input  logic              cpu_cs_i,
	input  logic              cpu_we_i,
	input  logic [ADDR_W-1:0] cpu_addr_i,
	input  logic [DATA_W-1:0] cpu_wdata_i,
	output logic [DATA_W-1:0] cpu_rdata_o,
	output logic              cpu_ready_o
);

	// ========================================
	// Channels
	// ========================================

	logic              host_req;
	logic              host_we;
	logic [ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic [DATA_W-1:0] host_rdata;
	logic              host_ack;

	logic              cpu_req;
	logic              cpu_we;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wdata;
	logic [DATA_W-1:0] cpu_rdata;
	logic              cpu_ack;

	logic              ram_en;
	logic              ram_we;
	logic [ADDR_W-1:0] ram_addr;
	logic [DATA_W-1:0] ram_wdata;
	logic [DATA_W-1:0] ram_rdata;

	host_xfer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_host (
		.clk_12         (clk_12),
		.reset_i        (reset_i),
		.ioctl_wr_i     (ioctl_wr_i),
		.ioctl_upload_i (ioctl_upload_i),
		.ioctl_addr_i   (ioctl_addr_i),
		.ioctl_dout_i   (ioctl_dout_i),
		.ioctl_din_o    (ioctl_din_o),
		.busy_o         (host_busy_o),
		.host_req_o     (host_req),
		.host_we_o      (host_we),
		.host_addr_o    (host_addr),
		.host_wdata_o   (host_wdata),
		.host_ack_i     (host_ack),
		.host_rdata_i   (host_rdata)
	);

	cpu_port #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_cpu (
		.clk_12      (clk_12),
		.reset_i     (reset_i),
		.cpu_cs_i    (cpu_cs_i),
		.cpu_we_i    (cpu_we_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_wdata_i (cpu_wdata_i),
		.cpu_rdata_o (cpu_rdata_o),
		.cpu_ready_o (cpu_ready_o),
		.req_o       (cpu_req),
		.we_o        (cpu_we),
		.addr_o      (cpu_addr),
		.wdata_o     (cpu_wdata),
		.ack_i       (cpu_ack),
		.rdata_i     (cpu_rdata)
	);

	// ========================================
	// Arbiter and table
	// ========================================

	hs_arbiter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_arb (
		.clk_12       (clk_12),
		.reset_i      (reset_i),
		.host_req_i   (host_req),
		.host_we_i    (host_we),
		.host_addr_i  (host_addr),
		.host_wdata_i (host_wdata),
		.host_ack_o   (host_ack),
		.host_rdata_o (host_rdata),
		.cpu_req_i    (cpu_req),
		.cpu_we_i     (cpu_we),
		.cpu_addr_i   (cpu_addr),
		.cpu_wdata_i  (cpu_wdata),
		.cpu_ack_o    (cpu_ack),
		.cpu_rdata_o  (cpu_rdata),
		.ram_en_o     (ram_en),
		.ram_we_o     (ram_we),
		.ram_addr_o   (ram_addr),
		.ram_wdata_o  (ram_wdata),
		.ram_rdata_i  (ram_rdata)
	);

	hs_ram #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_ram (
		.clk_12      (clk_12),
		.ram_en_i    (ram_en),
		.ram_we_i    (ram_we),
		.ram_addr_i  (ram_addr),
		.ram_wdata_i (ram_wdata),
		.ram_rdata_o (ram_rdata)
	);

endmodule

// File: cpu_port.sv
// Game CPU access port
// Turns chip-select cycles into four-phase transactions and answers
// with a one-cycle ready pulse
module cpu_port #(
	parameter int ADDR_W = 6,
	parameter int DATA_W = 8
) (
	input  logic              clk_12,
	input  logic              reset_i,
	// CPU side
	input  logic              cpu_cs_i,
	input  logic              cpu_we_i,
	input  logic [ADDR_W-1:0] cpu_addr_i,
	input  logic [DATA_W-1:0] cpu_wdata_i,
	output logic [DATA_W-1:0] cpu_rdata_o,
	output logic              cpu_ready_o,
	// CPU channel
	output logic              req_o,
	output logic              we_o,
	output logic [ADDR_W-1:0] addr_o,
	output logic [DATA_W-1:0] wdata_o,
	input  logic              ack_i,
	input  logic [DATA_W-1:0] rdata_i
);

	hs_pkg::port_state_t state_q;
	logic                start;
	logic                ack_seen;

	// No transaction open once ack has fallen
	assign start = cpu_cs_i && ((state_q == hs_pkg::IDLE) ||
		((state_q == hs_pkg::RELEASE) && !ack_i));

	assign ack_seen = (state_q == hs_pkg::REQ) && ack_i;
	assign req_o    = (state_q == hs_pkg::REQ);

	always_ff @(posedge clk_12) begin
		if (reset_i) begin
			state_q     <= hs_pkg::IDLE;
			cpu_ready_o <= 1'b0;
		end else begin
			cpu_ready_o <= ack_seen;
			if (start) begin
				state_q <= hs_pkg::REQ;
			end else if (ack_seen) begin
				state_q <= hs_pkg::RELEASE;
			end else if ((state_q == hs_pkg::RELEASE) && !ack_i) begin
				state_q <= hs_pkg::IDLE;
			end
		end
	end

	// Registered CPU cycle keeps the channel stable while the CPU waits
	always_ff @(posedge clk_12) begin
		if (start) begin
			we_o    <= cpu_we_i;
			addr_o  <= cpu_addr_i;
			wdata_o <= cpu_wdata_i;
		end
	end

	// Valid with the ready pulse, held afterwards
	always_ff @(posedge clk_12) begin
		if (ack_seen) begin
			cpu_rdata_o <= rdata_i;
		end
	end

endmodule

// File: host_xfer.sv
// Host loader port
// Turns configuration byte strobes into four-phase transactions on the
// host channel and returns upload bytes on ioctl_din_o
module host_xfer #(
	parameter int ADDR_W = 6,
	parameter int DATA_W = 8
) (
	input  logic              clk_12,
	input  logic              reset_i,
	// Byte strobe side
	input  logic              ioctl_wr_i,
	input  logic              ioctl_upload_i,
	input  logic [ADDR_W-1:0] ioctl_addr_i,
	input  logic [DATA_W-1:0] ioctl_dout_i,
	output logic [DATA_W-1:0] ioctl_din_o,
	output logic              busy_o,
	// Host channel
	output logic              host_req_o,
	output logic              host_we_o,
	output logic [ADDR_W-1:0] host_addr_o,
	output logic [DATA_W-1:0] host_wdata_o,
	input  logic              host_ack_i,
	input  logic [DATA_W-1:0] host_rdata_i
);

	hs_pkg::port_state_t state_q;
	logic                accept;

	// ========================================
	// Handshake status
	// ========================================

	// Busy drops in the cycle the arbiter lets go of ack
	assign busy_o = (state_q == hs_pkg::REQ) ||
		((state_q == hs_pkg::RELEASE) && host_ack_i);

	// A strobe while busy is dropped
	assign accept = ioctl_wr_i && !busy_o;

	assign host_req_o = (state_q == hs_pkg::REQ);

	always_ff @(posedge clk_12) begin
		if (reset_i) begin
			state_q <= hs_pkg::IDLE;
		end else begin
			case (state_q)
				hs_pkg::IDLE: begin
					if (accept) begin
						state_q <= hs_pkg::REQ;
					end
				end
				hs_pkg::REQ: begin
					if (host_ack_i) begin
						state_q <= hs_pkg::RELEASE;
					end
				end
				hs_pkg::RELEASE: begin
					// Ack is down, so a new strobe can go straight out
					if (!host_ack_i) begin
						state_q <= accept ? hs_pkg::REQ : hs_pkg::IDLE;
					end
				end
				default: begin
					state_q <= hs_pkg::IDLE;
				end
			endcase
		end
	end

	// ========================================
	// Payload
	// ========================================

	// Strobed address and byte stay stable for the whole transaction
	always_ff @(posedge clk_12) begin
		if (accept) begin
			host_we_o    <= !ioctl_upload_i;
			host_addr_o  <= ioctl_addr_i;
			host_wdata_o <= ioctl_dout_i;
		end
	end

	// Upload byte is kept until the next read completes
	always_ff @(posedge clk_12) begin
		if ((state_q == hs_pkg::REQ) && host_ack_i && !host_we_o) begin
			ioctl_din_o <= host_rdata_i;
		end
	end

endmodule

// File: hs_arbiter.sv
// Round-robin arbiter between the host loader and the CPU port
// Serves one four-phase transaction at a time onto the table RAM
module hs_arbiter #(
	parameter int ADDR_W = 6,
	parameter int DATA_W = 8
) (
	input  logic              clk_12,
	input  logic              reset_i,
	// Host channel
	input  logic              host_req_i,
	input  logic              host_we_i,
	input  logic [ADDR_W-1:0] host_addr_i,
	input  logic [DATA_W-1:0] host_wdata_i,
	output logic              host_ack_o,
	output logic [DATA_W-1:0] host_rdata_o,
	// CPU channel
	input  logic              cpu_req_i,
	input  logic              cpu_we_i,
	input  logic [ADDR_W-1:0] cpu_addr_i,
	input  logic [DATA_W-1:0] cpu_wdata_i,
	output logic              cpu_ack_o,
	output logic [DATA_W-1:0] cpu_rdata_o,
	// RAM side
	output logic              ram_en_o,
	output logic              ram_we_o,
	output logic [ADDR_W-1:0] ram_addr_o,
	output logic [DATA_W-1:0] ram_wdata_o,
	input  logic [DATA_W-1:0] ram_rdata_i
);

	// IDLE grants and strobes the RAM, ACCESS catches the read data,
	// HOLD keeps ack up until the owner drops its request
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		HOLD
	} arb_state_t;

	arb_state_t     state_q;
	hs_pkg::owner_t owner_q;
	hs_pkg::owner_t favour_q;
	hs_pkg::owner_t grant_sel;
	logic           any_req;
	logic           owner_req;

	assign any_req   = host_req_i | cpu_req_i;
	assign owner_req = (owner_q == hs_pkg::OWNER_CPU) ? cpu_req_i : host_req_i;

	// On a tie the favour register decides
	always_comb begin
		if (host_req_i && cpu_req_i) begin
			grant_sel = favour_q;
		end else if (cpu_req_i) begin
			grant_sel = hs_pkg::OWNER_CPU;
		end else begin
			grant_sel = hs_pkg::OWNER_HOST;
		end
	end

	// ========================================
	// RAM strobe, same cycle as the grant
	// ========================================

	assign ram_en_o    = (state_q == IDLE) && any_req;
	assign ram_we_o    = (grant_sel == hs_pkg::OWNER_CPU) ? cpu_we_i    : host_we_i;
	assign ram_addr_o  = (grant_sel == hs_pkg::OWNER_CPU) ? cpu_addr_i  : host_addr_i;
	assign ram_wdata_o = (grant_sel == hs_pkg::OWNER_CPU) ? cpu_wdata_i : host_wdata_i;

	// ========================================
	// Grant FSM and ack half of the handshake
	// ========================================

	always_ff @(posedge clk_12) begin
		if (reset_i) begin
			state_q    <= IDLE;
			owner_q    <= hs_pkg::OWNER_HOST;
			favour_q   <= hs_pkg::OWNER_HOST;
			host_ack_o <= 1'b0;
			cpu_ack_o  <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (any_req) begin
						owner_q <= grant_sel;
						// Favour passes to the peer that was not served
						if (grant_sel == hs_pkg::OWNER_HOST) begin
							favour_q <= hs_pkg::OWNER_CPU;
						end else begin
							favour_q <= hs_pkg::OWNER_HOST;
						end
						state_q <= ACCESS;
					end
				end
				ACCESS: begin
					host_ack_o <= (owner_q == hs_pkg::OWNER_HOST);
					cpu_ack_o  <= (owner_q == hs_pkg::OWNER_CPU);
					state_q    <= HOLD;
				end
				HOLD: begin
					if (!owner_req) begin
						host_ack_o <= 1'b0;
						cpu_ack_o  <= 1'b0;
						state_q    <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// RAM output is valid during ACCESS and goes only to the owner
	always_ff @(posedge clk_12) begin
		if (state_q == ACCESS) begin
			if (owner_q == hs_pkg::OWNER_CPU) begin
				cpu_rdata_o <= ram_rdata_i;
			end else begin
				host_rdata_o <= ram_rdata_i;
			end
		end
	end

endmodule

// File: hs_ram.sv
// High-score table RAM
// Single port, one access per enabled cycle, read data registered
module hs_ram #(
	parameter int ADDR_W = 6,
	parameter int DATA_W = 8
) (
	input  logic              clk_12,
	input  logic              ram_en_i,
	input  logic              ram_we_i,
	input  logic [ADDR_W-1:0] ram_addr_i,
	input  logic [DATA_W-1:0] ram_wdata_i,
	output logic [DATA_W-1:0] ram_rdata_o
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [DATA_W-1:0] mem [0:DEPTH-1];

	// A write returns the new byte, so the owner sees what was stored
	always_ff @(posedge clk_12) begin
		if (ram_en_i) begin
			if (ram_we_i) begin
				mem[ram_addr_i] <= ram_wdata_i;
				ram_rdata_o     <= ram_wdata_i;
			end else begin
				ram_rdata_o <= mem[ram_addr_i];
			end
		end
	end

endmodule

// File: hs_pkg.sv
// High-score store shared definitions
// Default table geometry and the state and owner encodings used by the
// peers and the arbiter
package hs_pkg;

	// ========================================
	// Default geometry
	// ========================================

	// 64 entries of one byte each
	localparam int HS_ADDR_W_DEF = 6;
	localparam int HS_DATA_W_DEF = 8;

	// ========================================
	// Encodings
	// ========================================

	// Requesting side of a four-phase channel
	// REQ waits for ack to rise, RELEASE waits for ack to fall
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		RELEASE
	} port_state_t;

	// Which peer the arbiter is serving, or favours on the next tie
	typedef enum logic {
		OWNER_HOST,
		OWNER_CPU
	} owner_t;

endpackage
